// File: rtl/frame_vram.sv
`timescale 1ns/1ps

module frame_vram (
  input  logic                                clk,
  input  logic                                rst,
  input  led_pkg::vram_wr_t                   wr,
  input  logic                                rd,
  input  logic [led_pkg::ADDR_BITS-1:0]       addr,
  output logic [led_pkg::ROW_WORD_BITS-1:0]   rd_data,
  output logic                                done_read
);
  import led_pkg::*;

  logic [ROW_WORD_BITS-1:0] mem [2*ROWS_PER_HALF];
  logic [ADDR_BITS-1:0]     rd_addr_q;
  logic [$clog2(VRAM_READ_LATENCY)-1:0] lat_cnt;

  // pixel write port, one byte lane per column
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.row_addr][wr.col*$bits(pixel_u) +: $bits(pixel_u)] <= wr.pixel.raw;
    end
  end

  // latency counter, done lands on the last count
  always_ff @(posedge clk) begin
    if (rst) begin
      lat_cnt   <= '0;
      done_read <= 1'b0;
    end else begin
      done_read <= 1'b0;
      if (rd) begin
        lat_cnt <= ($clog2(VRAM_READ_LATENCY))'(VRAM_READ_LATENCY - 1);
      end else if (lat_cnt != '0) begin
        lat_cnt <= lat_cnt - 1'b1;
        if (lat_cnt == 1) begin
          done_read <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rd_addr_q <= addr;  // sampled with the strobe
    end
  end

  // data holds until the next read completes
  always_ff @(posedge clk) begin
    if (!rd && lat_cnt == 1) begin
      rd_data <= mem[rd_addr_q];
    end
  end

endmodule

// File: rtl/led_matrix_driver.sv
`timescale 1ns/1ps

module led_matrix_driver (
  input  logic                          clk,
  input  logic                          rst,
  input  led_pkg::vram_wr_t             vram_wr,
  input  logic                          cache,
  input  logic [led_pkg::ROW_BITS-1:0]  row,
  input  led_pkg::plane_t               plane,
  input  logic                          shift_plane,
  output logic [2:0]                    rgb0,
  output logic [2:0]                    rgb1,
  output logic                          sclk,
  output logic                          plane_ready,
  output logic [led_pkg::ROW_BITS-1:0]  row_addr
);
  import led_pkg::*;

  logic                      rd;
  logic                      done_read;
  logic [ADDR_BITS-1:0]      addr;
  logic [ROW_WORD_BITS-1:0]  rd_data;
  logic                      row_load0;
  logic                      row_load1;
  logic [ROW_WORD_BITS-1:0]  row0_data;
  logic [ROW_WORD_BITS-1:0]  row1_data;
  logic                      plane_load0;
  logic                      plane_load1;
  plane_rgb_t                plane_rgb;
  logic [5:0]                rgb01;

  frame_vram u_frame_vram (
    .clk       (clk),
    .rst       (rst),
    .wr        (vram_wr),
    .rd        (rd),
    .addr      (addr),
    .rd_data   (rd_data),
    .done_read (done_read)
  );

  row_buffer u_row_buffer (
    .clk       (clk),
    .rst       (rst),
    .rd_data   (rd_data),
    .row_load0 (row_load0),
    .row_load1 (row_load1),
    .row0_data (row0_data),
    .row1_data (row1_data)
  );

  memory_management u_memory_management (
    .clk         (clk),
    .rst         (rst),
    .cache       (cache),
    .row         (row),
    .plane       (plane),
    .shift_plane (shift_plane),
    .rgb01       (rgb01),
    .row0_data   (row0_data),
    .row1_data   (row1_data),
    .done_read   (done_read),
    .plane_ready (plane_ready),
    .plane_load0 (plane_load0),
    .plane_load1 (plane_load1),
    .plane_shift (sclk),  // shift strobe doubles as panel clock
    .row_load0   (row_load0),
    .row_load1   (row_load1),
    .rd          (rd),
    .addr        (addr),
    .rgb0        (rgb0),
    .rgb1        (rgb1),
    .plane_rgb   (plane_rgb),
    .row_addr    (row_addr)
  );

  panel_shifter u_panel_shifter (
    .clk         (clk),
    .rst         (rst),
    .plane_load0 (plane_load0),
    .plane_load1 (plane_load1),
    .plane_shift (sclk),
    .plane_rgb   (plane_rgb),
    .rgb01       (rgb01)
  );

endmodule

// File: rtl/led_pkg.sv
package led_pkg;

  localparam int COLS              = 64;
  localparam int ROWS_PER_HALF     = 32;
  localparam int ROW_BITS          = $clog2(ROWS_PER_HALF);  // 5
  localparam int ADDR_BITS         = ROW_BITS + 1;           // side, then row
  localparam int ROW_WORD_BITS     = COLS * 8;               // 512
  localparam int VRAM_READ_LATENCY = 3;

  // one RGB332 pixel, stored raw and decoded per channel
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [2:0] red;
      logic [2:0] green;
      logic [1:0] blue;
    } rgb;
  } pixel_u;

  typedef logic [1:0] plane_t;

  typedef struct packed {
    logic                     en;
    logic [ADDR_BITS-1:0]     row_addr;
    logic [$clog2(COLS)-1:0]  col;
    pixel_u                   pixel;
  } vram_wr_t;

  // one bit plane across a full row, bit i is column i
  typedef struct packed {
    logic [COLS-1:0] red;
    logic [COLS-1:0] green;
    logic [COLS-1:0] blue;
  } plane_rgb_t;

endpackage

// File: rtl/memory_management.sv
`timescale 1ns/1ps

module memory_management (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               cache,
  input  logic [led_pkg::ROW_BITS-1:0]       row,
  input  led_pkg::plane_t                    plane,
  input  logic                               shift_plane,
  input  logic [5:0]                         rgb01,
  input  logic [led_pkg::ROW_WORD_BITS-1:0]  row0_data,
  input  logic [led_pkg::ROW_WORD_BITS-1:0]  row1_data,
  input  logic                               done_read,
  output logic                               plane_ready,
  output logic                               plane_load0,
  output logic                               plane_load1,
  output logic                               plane_shift,
  output logic                               row_load0,
  output logic                               row_load1,
  output logic                               rd,
  output logic [led_pkg::ADDR_BITS-1:0]      addr,
  output logic [2:0]                         rgb0,
  output logic [2:0]                         rgb1,
  output led_pkg::plane_rgb_t                plane_rgb,
  output logic [led_pkg::ROW_BITS-1:0]       row_addr
);
  import led_pkg::*;

  typedef enum logic [3:0] {
    s_idle,
    s_shift,
    s_load0,
    s_load1,
    s_done,
    s_cache_row0,
    s_load_row0,
    s_cache_row1,
    s_load_row1
  } state_t;

  state_t               state;
  logic                 side;
  logic [ROW_BITS-1:0]  row_q;      // also the buffered row tag
  logic                 row_valid;
  plane_t               plane_q;
  logic [ROW_WORD_BITS-1:0] cache_row;

  assign addr      = {side, row_q};
  assign row_addr  = row_q;
  assign cache_row = side ? row1_data : row0_data;
  assign rgb0      = rgb01[5:3];
  assign rgb1      = rgb01[2:0];

  plane_selection u_plane_selection (
    .plane     (plane_q),
    .row_data  (cache_row),
    .plane_rgb (plane_rgb)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= s_idle;
      side        <= 1'b0;
      row_q       <= '0;
      row_valid   <= 1'b0;
      plane_q     <= '0;
      rd          <= 1'b0;
      row_load0   <= 1'b0;
      row_load1   <= 1'b0;
      plane_load0 <= 1'b0;
      plane_load1 <= 1'b0;
      plane_shift <= 1'b0;
      plane_ready <= 1'b0;
    end else begin
      rd          <= 1'b0;  // strobes default low
      row_load0   <= 1'b0;
      row_load1   <= 1'b0;
      plane_load0 <= 1'b0;
      plane_load1 <= 1'b0;
      plane_shift <= 1'b0;
      plane_ready <= 1'b0;
      case (state)
        s_idle: begin
          if (shift_plane) begin
            plane_shift <= 1'b1;
            side        <= 1'b0;
            state       <= s_shift;
          end else if (cache) begin
            row_q   <= row;
            plane_q <= plane;
            side    <= 1'b0;
            if (row_valid && row == row_q) begin
              plane_load0 <= 1'b1;  // hit, straight to the shifters
              state       <= s_load0;
            end else begin
              rd        <= 1'b1;
              row_valid <= 1'b0;
              state     <= s_cache_row0;
            end
          end
        end
        s_shift: begin
          if (shift_plane) begin
            plane_shift <= 1'b1;
          end else begin
            state <= s_idle;
          end
        end
        s_load0: begin
          plane_load1 <= 1'b1;
          side        <= 1'b1;
          state       <= s_load1;
        end
        s_load1: begin
          plane_ready <= 1'b1;
          side        <= 1'b0;
          state       <= s_done;
        end
        s_done: state <= s_idle;
        s_cache_row0: begin
          if (done_read) begin
            row_load0 <= 1'b1;
            state     <= s_load_row0;
          end
        end
        s_load_row0: begin
          rd    <= 1'b1;
          side  <= 1'b1;  // bottom half next
          state <= s_cache_row1;
        end
        s_cache_row1: begin
          if (done_read) begin
            row_load1 <= 1'b1;
            state     <= s_load_row1;
          end
        end
        s_load_row1: begin
          plane_load0 <= 1'b1;
          side        <= 1'b0;
          row_valid   <= 1'b1;
          state       <= s_load0;
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

// File: rtl/panel_shifter.sv
`timescale 1ns/1ps

module panel_shifter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 plane_load0,
  input  logic                 plane_load1,
  input  logic                 plane_shift,
  input  led_pkg::plane_rgb_t  plane_rgb,
  output logic [5:0]           rgb01
);
  import led_pkg::*;

  plane_rgb_t top_q;
  plane_rgb_t bot_q;

  // advance one pixel, zero fill at column COLS-1
  function automatic plane_rgb_t shift_one(input plane_rgb_t v);
    plane_rgb_t s;
    s.red   = v.red >> 1;
    s.green = v.green >> 1;
    s.blue  = v.blue >> 1;
    return s;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      top_q <= '0;
    end else if (plane_load0) begin
      top_q <= plane_rgb;
    end else if (plane_shift) begin
      top_q <= shift_one(top_q);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bot_q <= '0;
    end else if (plane_load1) begin
      bot_q <= plane_rgb;
    end else if (plane_shift) begin
      bot_q <= shift_one(bot_q);
    end
  end

  assign rgb01 = {top_q.red[0], top_q.green[0], top_q.blue[0],
                  bot_q.red[0], bot_q.green[0], bot_q.blue[0]};  // pixel 0 of each half

endmodule

// File: rtl/plane_selection.sv
`timescale 1ns/1ps

module plane_selection (
  input  led_pkg::plane_t                    plane,
  input  logic [led_pkg::ROW_WORD_BITS-1:0]  row_data,
  output led_pkg::plane_rgb_t                plane_rgb
);
  import led_pkg::*;

  // blue has only two bits, so it lags red and green by one plane
  always_comb begin
    pixel_u px;
    plane_rgb = '0;
    for (int i = 0; i < COLS; i++) begin
      px.raw = row_data[i*$bits(pixel_u) +: $bits(pixel_u)];
      if (plane != 2'd3) begin
        plane_rgb.red[i]   = px.rgb.red[plane];
        plane_rgb.green[i] = px.rgb.green[plane];
        if (plane != 2'd0) begin
          plane_rgb.blue[i] = px.rgb.blue[1'(plane - 2'd1)];
        end
      end
    end
  end

endmodule

// File: rtl/row_buffer.sv
`timescale 1ns/1ps

module row_buffer (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [led_pkg::ROW_WORD_BITS-1:0]  rd_data,
  input  logic                               row_load0,
  input  logic                               row_load1,
  output logic [led_pkg::ROW_WORD_BITS-1:0]  row0_data,
  output logic [led_pkg::ROW_WORD_BITS-1:0]  row1_data
);

  // top half
  always_ff @(posedge clk) begin
    if (rst) begin
      row0_data <= '0;
    end else if (row_load0) begin
      row0_data <= rd_data;
    end
  end

  // bottom half
  always_ff @(posedge clk) begin
    if (rst) begin
      row1_data <= '0;
    end else if (row_load1) begin
      row1_data <= rd_data;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_led_matrix_driver -f tb.f -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tb.f
rtl/led_pkg.sv
rtl/frame_vram.sv
rtl/row_buffer.sv
rtl/plane_selection.sv
rtl/memory_management.sv
rtl/panel_shifter.sv
rtl/led_matrix_driver.sv
tb/tb_led_matrix_driver.sv

// File: tb/tb_led_matrix_driver.sv
`timescale 1ns/1ps

module tb_led_matrix_driver;
  import led_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int DRIVE_DELAY    = 2;
  localparam int HIT_LAT        = 3;
  localparam int MISS_LAT       = 3 + 2 * (VRAM_READ_LATENCY + 2);
  localparam int NUM_RANDOM     = 20;
  localparam int NUM_REQUESTS   = 7 + NUM_RANDOM;
  localparam int REQUEST_CYCLES = MISS_LAT + COLS + 8;
  localparam int SETUP_CYCLES   = 2 * ROWS_PER_HALF * COLS + 64;
  localparam int WATCHDOG_NS    =
    (SETUP_CYCLES + NUM_REQUESTS * REQUEST_CYCLES + 200) * CLK_PERIOD;
  localparam logic [31:0] RAND_SEED = 32'h9b08_8f1e;

  logic                 clk;
  logic                 rst;
  vram_wr_t             vram_wr;
  logic                 cache;
  logic [ROW_BITS-1:0]  row;
  plane_t               plane;
  logic                 shift_plane;
  logic [2:0]           rgb0;
  logic [2:0]           rgb1;
  logic                 sclk;
  logic                 plane_ready;
  logic [ROW_BITS-1:0]  row_addr;

  logic [7:0]           frame_ref [2*ROWS_PER_HALF][COLS];  // side, then row
  string                cur_test;
  logic [ROW_BITS-1:0]  cur_row;
  plane_t               cur_plane;
  int                   sample_idx;
  int                   test_errors;
  int                   total_errors;
  int                   checks;
  int                   tests_run;
  int                   tests_failed;
  logic                 buf_valid;  // model of the buffered row
  logic [ROW_BITS-1:0]  buf_row;

  led_matrix_driver UUT (
    .clk         (clk),
    .rst         (rst),
    .vram_wr     (vram_wr),
    .cache       (cache),
    .row         (row),
    .plane       (plane),
    .shift_plane (shift_plane),
    .rgb0        (rgb0),
    .rgb1        (rgb1),
    .sclk        (sclk),
    .plane_ready (plane_ready),
    .row_addr    (row_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired in test %s, the run did not finish in time", cur_test);
    $display("STATUS: FAIL");
    $finish;
  end

  task automatic note_error();
    test_errors++;
    total_errors++;
  endtask

  // RGB332 byte: red [7:5], green [4:2], blue [1:0]
  function automatic logic [2:0] expected_pixel(input logic [ROW_BITS-1:0] r,
                                                input logic side,
                                                input logic [5:0] col,
                                                input plane_t p);
    logic [7:0] b;
    b = frame_ref[{side, r}][col];
    case (p)
      2'd0:    return {b[5], b[2], 1'b0};  // blue has no plane 0
      2'd1:    return {b[6], b[3], b[0]};
      2'd2:    return {b[7], b[4], b[1]};
      default: return 3'b000;
    endcase
  endfunction

  function automatic int predict_latency(input logic [ROW_BITS-1:0] r);
    if (buf_valid && buf_row == r) begin
      return HIT_LAT;
    end
    return MISS_LAT;
  endfunction

  // compare while the panel clock is high, mid-cycle
  always @(negedge clk) begin
    logic [2:0] exp0;
    logic [2:0] exp1;
    if (!rst && sclk) begin
      assert (sample_idx < COLS) else begin
        $display("%s: shift clock kept running past the last column", cur_test);
        note_error();
      end
      if (sample_idx < COLS) begin
        exp0 = expected_pixel(cur_row, 1'b0, 6'(sample_idx), cur_plane);
        exp1 = expected_pixel(cur_row, 1'b1, 6'(sample_idx), cur_plane);
        checks += 2;
        assert (rgb0 === exp0) else begin
          $display("ERR %s: rgb0 row %0d col %0d expected %b actual %b",
                   cur_test, cur_row, sample_idx, exp0, rgb0);
          note_error();
        end
        assert (rgb1 === exp1) else begin
          $display("ERR %s: rgb1 row %0d col %0d expected %b actual %b",
                   cur_test, cur_row, sample_idx, exp1, rgb1);
          note_error();
        end
      end
      sample_idx++;
    end
  end

  task automatic write_pixel(input logic [ADDR_BITS-1:0] a,
                             input logic [5:0] col,
                             input logic [7:0] value);
    frame_ref[a][col] = value;
    vram_wr.en        = 1'b1;
    vram_wr.row_addr  = a;
    vram_wr.col       = col;
    vram_wr.pixel.raw = value;
    @(posedge clk);
    #DRIVE_DELAY;
    vram_wr.en = 1'b0;
  endtask

  task automatic load_frame();
    for (int a = 0; a < 2 * ROWS_PER_HALF; a++) begin
      for (int c = 0; c < COLS; c++) begin
        write_pixel(6'(a), 6'(c), 8'($urandom));
      end
    end
  endtask

  // one request, latency check, then a full 64 column stream
  task automatic request_plane(input logic [ROW_BITS-1:0] r, input plane_t p,
                               input int exp_lat);
    int   lat;
    logic seen;
    cur_row    = r;
    cur_plane  = p;
    sample_idx = 0;
    cache      = 1'b1;
    row        = r;
    plane      = p;
    @(posedge clk);
    #DRIVE_DELAY;
    cache = 1'b0;
    lat   = 0;
    seen  = 1'b0;
    while (!seen && lat < MISS_LAT + 8) begin
      @(negedge clk);
      lat++;
      seen = plane_ready;
    end
    checks += 2;
    assert (seen) else begin
      $display("%s: plane_ready never came for row %0d plane %0d", cur_test, r, p);
      note_error();
    end
    if (seen) begin
      assert (lat == exp_lat) else begin
        $display("ERR %s: latency row %0d expected %0d actual %0d", cur_test, r, exp_lat, lat);
        note_error();
      end
    end
    assert (row_addr == r) else begin
      $display("ERR %s: row_addr expected %0d actual %0d", cur_test, r, row_addr);
      note_error();
    end
    buf_valid = 1'b1;
    buf_row   = r;
    @(posedge clk);
    #DRIVE_DELAY;
    shift_plane = 1'b1;
    repeat (COLS) @(posedge clk);
    #DRIVE_DELAY;
    shift_plane = 1'b0;
    @(posedge clk);
    @(negedge clk);
    checks++;
    assert (sample_idx == COLS && !sclk) else begin
      $display("%s: stream gave %0d columns instead of %0d", cur_test, sample_idx, COLS);
      note_error();
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
    sample_idx  = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, test_errors);
    end
  endtask

  initial begin
    logic [ROW_BITS-1:0]  r;
    plane_t               p;
    logic [ADDR_BITS-1:0] a_top;
    logic [ADDR_BITS-1:0] a_bot;
    rst          = 1'b1;
    vram_wr      = '0;
    cache        = 1'b0;
    row          = '0;
    plane        = '0;
    shift_plane  = 1'b0;
    cur_test     = "reset";
    cur_row      = '0;
    cur_plane    = '0;
    sample_idx   = 0;
    test_errors  = 0;
    total_errors = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    buf_valid    = 1'b0;
    buf_row      = '0;
    void'($urandom(RAND_SEED));
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    begin_test("reset_idle");
    repeat (10) begin
      @(negedge clk);
      checks++;
      assert (!sclk && !plane_ready) else begin
        $display("%s: sclk or plane_ready went high with no request", cur_test);
        note_error();
      end
    end
    @(posedge clk);
    #DRIVE_DELAY;
    end_test();

    load_frame();

    begin_test("miss_plane0");
    request_plane(5'd5, 2'd0, MISS_LAT);
    end_test();

    begin_test("hit_planes");
    request_plane(5'd5, 2'd1, HIT_LAT);
    request_plane(5'd5, 2'd2, HIT_LAT);  // blue lags one plane
    end_test();

    begin_test("plane3_zero");
    request_plane(5'd5, 2'd3, HIT_LAT);
    end_test();

    begin_test("rewrite_reread");
    a_top = {1'b0, 5'd9};
    a_bot = {1'b1, 5'd9};
    request_plane(5'd9, 2'd0, MISS_LAT);
    request_plane(5'd22, 2'd1, MISS_LAT);
    for (int c = 0; c < COLS; c += 4) begin
      write_pixel(a_top, 6'(c), ~frame_ref[a_top][6'(c)]);
      write_pixel(a_bot, 6'(c), ~frame_ref[a_bot][6'(c)]);
    end
    request_plane(5'd9, 2'd2, MISS_LAT);
    end_test();

    begin_test("random_requests");
    for (int i = 0; i < NUM_RANDOM; i++) begin
      if (buf_valid && ($urandom % 2 == 0)) begin
        r = buf_row;  // bias toward hits
      end else begin
        r = 5'($urandom % ROWS_PER_HALF);
      end
      p = 2'($urandom % 4);
      request_plane(r, p, predict_latency(r));
    end
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errors);
    if (total_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
